// File: filelist.f
+incdir+hdl
hdl/mpu_pkg.sv
hdl/mpu_bus_decode.sv
hdl/mpu_pit.sv
hdl/mpu_pic.sv
hdl/mpu_periph_top.sv
verif/tb_mpu.sv

// File: hdl/mpu_bus_decode.sv
`timescale 1ns/1ns
`include "mpu_consts.svh"

module mpu_bus_decode (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            cyc_i,
	input  logic            stb_i,
	input  mpu_pkg::addr_t  adr_i,
	input  mpu_pkg::sel_t   sel_i,
	input  mpu_pkg::data_t  dat_i,
	input  logic            pit_ack_i,
	input  mpu_pkg::reg32_t pit_dat_i,
	input  logic            pic_ack_i,
	input  mpu_pkg::reg32_t pic_dat_i,
	output logic            cs_pit_o,
	output logic            cs_pic_o,
	output mpu_pkg::addr_t  adr32_o,
	output mpu_pkg::reg32_t dat32_o,
	output logic            ack_o,
	output logic            err_o,
	output mpu_pkg::data_t  dat_o
);
	import mpu_pkg::*;

	localparam addr_t PIT_BASE = `MPU_PIT_BASE;
	localparam addr_t PIC_BASE = `MPU_PIC_BASE;

	logic  unmapped;  // live request hitting neither block
	logic  err_q;     // first stage of the error response
	data_t rd_mux;    // next read word

	// ====================
	// chip selects
	// ====================
	assign cs_pit_o = adr_i[31:8] == PIT_BASE[31:8];
	assign cs_pic_o = adr_i[31:8] == PIC_BASE[31:8];
	assign unmapped = cyc_i & stb_i & ~cs_pit_o & ~cs_pic_o;

	// rebuild a2 from the byte selects, the upper lane means a2 set
	assign adr32_o = {adr_i[31:3], |sel_i[7:4], 2'b00};
	assign dat32_o = |sel_i[7:4] ? dat_i[63:32] : dat_i[31:0];  // pick the live lane

	// interrupt controller wins if both ever ack together
	always_comb begin
		if (pic_ack_i)
			rd_mux = {2{pic_dat_i}};
		else if (pit_ack_i)
			rd_mux = {2{pit_dat_i}};
		else
			rd_mux = '0;
	end

	// ====================
	// response register
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
			err_q <= 1'b0;
			err_o <= 1'b0;
		end else begin
			ack_o <= pit_ack_i | pic_ack_i;
			// one shot per request, same spacing as a peripheral ack
			err_q <= unmapped & ~err_q;
			err_o <= err_q;
		end
	end

	// 32 bit data is mirrored into both halves
	always_ff @(posedge clk_i) begin
		dat_o <= rd_mux;
	end

endmodule

// File: hdl/mpu_consts.svh
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// ====================
// address map
// ====================
// each block decodes on adr[31:8], so 256 bytes apiece
`define MPU_PIT_BASE       32'hFFDC1100  // interval timer
`define MPU_PIC_BASE       32'hFFDC0F00  // interrupt controller

`define MPU_PIT_COUNT      3             // down-counters in the timer
`define MPU_IRQ_SRCS       32            // interrupt sources, 0 is never used

// ====================
// timer registers
// ====================
// timer n lives at n*16, offsets below are within its slot
`define MPU_PIT_COUNT_OFS  4'h0          // current count, read only
`define MPU_PIT_RELOAD_OFS 4'h4
`define MPU_PIT_CTRL_OFS   4'h8
`define MPU_PIT_CTRL_EN    0             // ctrl bit positions
`define MPU_PIT_CTRL_AR    1             // auto reload
`define MPU_PIT_CTRL_LD    2             // load now, reads back as 0

// ====================
// interrupt controller
// ====================
`define MPU_PIC_CAUSE      6'h00         // read only
`define MPU_PIC_ENABLE     6'h04
`define MPU_PIC_PENDING    6'h08         // write 1 to clear
`define MPU_PIC_EDGE       6'h0C         // 1 = edge triggered
`define MPU_PIC_LEVEL0     6'h20         // sources 0..7, one nibble each
`define MPU_PIC_LEVEL1     6'h24
`define MPU_PIC_LEVEL2     6'h28
`define MPU_PIC_LEVEL3     6'h2C         // sources 24..31

`endif

// File: hdl/mpu_periph_top.sv
`timescale 1ns/1ns
`include "mpu_consts.svh"

module mpu_periph_top (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  mpu_pkg::addr_t    adr_i,
	input  mpu_pkg::sel_t     sel_i,
	input  mpu_pkg::data_t    dat_i,
	input  logic [28:0]       irq_src_i,   // bit 0 has no source behind it
	input  logic              pit_gate2_i,
	output logic              ack_o,
	output logic              err_o,
	output mpu_pkg::data_t    dat_o,
	output mpu_pkg::irq_lvl_t irq_o,
	output mpu_pkg::cause_t   cause_o,
	output logic              pit_out2_o
);
	import mpu_pkg::*;

	logic   cs_pit;
	logic   cs_pic;
	addr_t  adr32;  // lane address for the 32 bit blocks
	reg32_t dat32;
	logic   pit_ack;
	reg32_t pit_dat;
	logic   pic_ack;
	reg32_t pic_dat;

	logic [`MPU_PIT_COUNT-1:0] pit_out;
	logic [`MPU_IRQ_SRCS-1:0]  pic_src;

	// timer 0 on the top source, then 1 and 2 below it
	assign pic_src    = {pit_out[0], pit_out[1], pit_out[2], irq_src_i[28:1], 1'b0};
	assign pit_out2_o = pit_out[2];

	// ====================
	// blocks
	// ====================
	mpu_bus_decode u_dec (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.adr_i     (adr_i),
		.sel_i     (sel_i),
		.dat_i     (dat_i),
		.pit_ack_i (pit_ack),
		.pit_dat_i (pit_dat),
		.pic_ack_i (pic_ack),
		.pic_dat_i (pic_dat),
		.cs_pit_o  (cs_pit),
		.cs_pic_o  (cs_pic),
		.adr32_o   (adr32),
		.dat32_o   (dat32),
		.ack_o     (ack_o),
		.err_o     (err_o),
		.dat_o     (dat_o)
	);

	mpu_pit u_pit (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.cs_i    (cs_pit),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.adr_i   (adr32[5:0]),
		.dat_i   (dat32),
		.gate2_i (pit_gate2_i),
		.ack_o   (pit_ack),
		.dat_o   (pit_dat),
		.out_o   (pit_out)
	);

	mpu_pic u_pic (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.cs_i    (cs_pic),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.adr_i   (adr32[5:0]),
		.dat_i   (dat32),
		.src_i   (pic_src),
		.ack_o   (pic_ack),
		.dat_o   (pic_dat),
		.irq_o   (irq_o),
		.cause_o (cause_o)
	);

endmodule

// File: hdl/mpu_pic.sv
`timescale 1ns/1ns
`include "mpu_consts.svh"

module mpu_pic (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             cs_i,
	input  logic             cyc_i,
	input  logic             stb_i,
	input  logic             we_i,
	input  logic [5:0]       adr_i,
	input  mpu_pkg::reg32_t  dat_i,
	input  logic [31:0]      src_i,
	output logic             ack_o,
	output mpu_pkg::reg32_t  dat_o,
	output mpu_pkg::irq_lvl_t irq_o,
	output mpu_pkg::cause_t  cause_o
);
	import mpu_pkg::*;

	logic req;
	logic wr;

	// source pipeline for edge detect
	logic [`MPU_IRQ_SRCS-1:0] src_d1;
	logic [`MPU_IRQ_SRCS-1:0] src_d2;
	logic [`MPU_IRQ_SRCS-1:0] rise;
	logic [`MPU_IRQ_SRCS-1:0] clr;       // write-1-to-clear mask

	reg32_t   en_q;
	reg32_t   edge_mode_q;
	reg32_t   pend_q;                    // sticky, edge sources only
	reg32_t   pend_eff;                  // what software sees
	reg32_t   act;                       // pending and enabled
	irq_lvl_t lvl_q [`MPU_IRQ_SRCS];

	cause_t   win;                       // highest active source
	cause_t   cause_q;
	irq_lvl_t irq_q;
	reg32_t   lvl_rd;
	reg32_t   rd_val;

	assign req = cs_i & cyc_i & stb_i & ~ack_o;
	assign wr  = req & we_i;

	// ====================
	// capture
	// ====================
	assign rise = src_d1 & ~src_d2;
	assign clr  = (wr && adr_i == `MPU_PIC_PENDING) ? dat_i : '0;

	// level sources follow the pin directly
	assign pend_eff = pend_q | (src_i & ~edge_mode_q);
	assign act      = pend_eff & en_q;

	// later sources overwrite earlier, so the top one wins
	always_comb begin
		win = '0;
		for (int k = 1; k < `MPU_IRQ_SRCS; k++) begin
			if (act[k])
				win = cause_t'(k);
		end
	end

	// ====================
	// registers
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o       <= 1'b0;
			src_d1      <= '0;
			src_d2      <= '0;
			pend_q      <= '0;
			en_q        <= '0;
			edge_mode_q <= '0;
			cause_q     <= '0;
			irq_q       <= '0;
			for (int k = 0; k < `MPU_IRQ_SRCS; k++)
				lvl_q[k] <= '0;
		end else begin
			ack_o  <= req;
			src_d1 <= src_i;
			src_d2 <= src_d1;
			// a new edge beats a clear in the same cycle
			pend_q <= ((pend_q & ~clr) | rise) & edge_mode_q;
			cause_q <= win;
			irq_q   <= (win != '0) ? lvl_q[win[4:0]] : '0;
			if (wr) begin
				case (adr_i)
					`MPU_PIC_ENABLE: en_q        <= dat_i;
					`MPU_PIC_EDGE:   edge_mode_q <= dat_i;
					`MPU_PIC_LEVEL0, `MPU_PIC_LEVEL1,
					`MPU_PIC_LEVEL2, `MPU_PIC_LEVEL3: begin
						// eight nibbles, register n holds sources 8n..8n+7
						for (int j = 0; j < 8; j++)
							lvl_q[{adr_i[3:2], 3'(j)}] <= dat_i[4*j +: 4];
					end
					default: ;  // cause is read only, pending handled above
				endcase
			end
		end
	end

	// ====================
	// read back
	// ====================
	always_comb begin
		lvl_rd = '0;
		for (int j = 0; j < 8; j++)
			lvl_rd[4*j +: 4] = lvl_q[{adr_i[3:2], 3'(j)}];
	end

	always_comb begin
		case (adr_i)
			`MPU_PIC_CAUSE:   rd_val = reg32_t'(cause_q);
			`MPU_PIC_ENABLE:  rd_val = en_q;
			`MPU_PIC_PENDING: rd_val = pend_eff;
			`MPU_PIC_EDGE:    rd_val = edge_mode_q;
			`MPU_PIC_LEVEL0, `MPU_PIC_LEVEL1,
			`MPU_PIC_LEVEL2, `MPU_PIC_LEVEL3: rd_val = lvl_rd;
			default:          rd_val = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (req)
			dat_o <= rd_val;
	end

	assign cause_o = cause_q;
	assign irq_o   = irq_q;  // level of the current winner

endmodule

// File: hdl/mpu_pit.sv
`timescale 1ns/1ns
`include "mpu_consts.svh"

module mpu_pit (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            cs_i,
	input  logic            cyc_i,
	input  logic            stb_i,
	input  logic            we_i,
	input  logic [5:0]      adr_i,
	input  mpu_pkg::reg32_t dat_i,
	input  logic            gate2_i,
	output logic            ack_o,
	output mpu_pkg::reg32_t dat_o,
	output logic [2:0]      out_o
);
	import mpu_pkg::*;

	logic       req;   // request taken this cycle
	logic       wr;
	logic [1:0] tsel;  // which timer slot
	logic [3:0] ofs;   // register within the slot

	// per timer state
	reg32_t                    count_q  [`MPU_PIT_COUNT];
	reg32_t                    reload_q [`MPU_PIT_COUNT];
	logic [`MPU_PIT_COUNT-1:0] en_q;
	logic [`MPU_PIT_COUNT-1:0] auto_q;
	logic [`MPU_PIT_COUNT-1:0] out_q;
	logic [`MPU_PIT_COUNT-1:0] run;  // counting this clock

	reg32_t rd_val;

	// ====================
	// bus side
	// ====================
	assign req  = cs_i & cyc_i & stb_i & ~ack_o;  // one sample per request
	assign wr   = req & we_i;
	assign tsel = adr_i[5:4];
	assign ofs  = adr_i[3:0];

	// only the last timer has a gate input
	assign run = en_q & {gate2_i, {(`MPU_PIT_COUNT-1){1'b1}}};

	always_comb begin
		rd_val = '0;
		// slot 3 is empty and reads zero
		if (tsel < 2'(`MPU_PIT_COUNT)) begin
			case (ofs)
				`MPU_PIT_COUNT_OFS:  rd_val = count_q[tsel];
				`MPU_PIT_RELOAD_OFS: rd_val = reload_q[tsel];
				`MPU_PIT_CTRL_OFS:   rd_val = {30'd0, auto_q[tsel], en_q[tsel]};
				default:             rd_val = '0;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= req;  // high for exactly one cycle
	end

	always_ff @(posedge clk_i) begin
		if (req)
			dat_o <= rd_val;
	end

	// ====================
	// counters
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int t = 0; t < `MPU_PIT_COUNT; t++) begin
				count_q[t]  <= '0;
				reload_q[t] <= '0;
			end
			en_q   <= '0;
			auto_q <= '0;
			out_q  <= '0;
		end else begin
			for (int t = 0; t < `MPU_PIT_COUNT; t++) begin
				// out fires once per pass through zero
				out_q[t] <= run[t] && (count_q[t] == '0);
				if (run[t]) begin
					if (count_q[t] != '0)
						count_q[t] <= count_q[t] - 32'd1;
					else if (auto_q[t])
						count_q[t] <= reload_q[t];  // extra cycle, period is reload+1
					else
						en_q[t] <= 1'b0;  // one shot stops at zero
				end

				// bus writes override the count logic
				if (wr && tsel == 2'(t)) begin
					case (ofs)
						`MPU_PIT_RELOAD_OFS: reload_q[t] <= dat_i;
						`MPU_PIT_CTRL_OFS: begin
							en_q[t]   <= dat_i[`MPU_PIT_CTRL_EN];
							auto_q[t] <= dat_i[`MPU_PIT_CTRL_AR];
							if (dat_i[`MPU_PIT_CTRL_LD])
								count_q[t] <= reload_q[t];
						end
						default: ;  // count is read only
					endcase
				end
			end
		end
	end

	assign out_o = out_q;

endmodule

// File: hdl/mpu_pkg.sv
package mpu_pkg;

	// ====================
	// bus side
	// ====================
	typedef logic [31:0] addr_t;     // byte address from the master
	typedef logic [63:0] data_t;     // full width data word
	typedef logic [7:0]  sel_t;      // one bit per byte lane

	// 32 bit peripherals see only one lane
	typedef logic [31:0] reg32_t;

	// ====================
	// interrupt side
	// ====================
	typedef logic [7:0]  cause_t;    // winning source number, 0 = none
	typedef logic [3:0]  irq_lvl_t;  // programmed priority level

endpackage

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line in the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_mpu -f filelist.f -o tb_mpu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_mpu_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Simulation passed" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1

// File: verif/tb_mpu.sv
`timescale 1ns/1ns
`include "mpu_consts.svh"

module tb_mpu;
	import mpu_pkg::*;

	logic        clk_i;
	logic        rst_n_i;
	logic        cyc_i;
	logic        stb_i;
	logic        we_i;
	addr_t       adr_i;
	sel_t        sel_i;
	data_t       dat_i;
	logic [28:0] irq_src_i;
	logic        pit_gate2_i;
	logic        ack_o;
	logic        err_o;
	data_t       dat_o;
	irq_lvl_t    irq_o;
	cause_t      cause_o;
	logic        pit_out2_o;

	logic [31:0] rng_q;   // xorshift state
	string       test_name;
	reg32_t      lv [4];  // level registers as last written
	logic        stb_q;   // strobe one cycle back
	logic        req_d1;
	logic        req_d2;  // request start from two cycles back

	mpu_periph_top dut (.*);

	always #2 clk_i = ~clk_i;

	// ====================
	// bus protocol checks
	// ====================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			stb_q  <= 1'b0;
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
		end else begin
			stb_q  <= stb_i;
			req_d1 <= cyc_i & stb_i & ~stb_q;  // first cycle of a request
			req_d2 <= req_d1;
		end
	end

	rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ack_o | err_o) == req_d2) else begin
		$display("bus response in %s was not 2 cycles after the request", test_name);
		stop_fail();
	end

	rsp_single: assert property (@(posedge clk_i) disable iff (!rst_n_i) !(ack_o & err_o))
		else begin
		$display("ack and err were both high in %s", test_name);
		stop_fail();
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] rand32();
		rng_q = xorshift32(rng_q);
		return rng_q;
	endfunction

	function automatic addr_t pit_reg(input int n, input logic [3:0] ofs);
		return `MPU_PIT_BASE + addr_t'(n * 16) + addr_t'(ofs);  // 16 byte slot per timer
	endfunction

	function automatic addr_t pic_reg(input logic [5:0] ofs);
		return `MPU_PIC_BASE + addr_t'(ofs);
	endfunction

	// nibble k mod 8 of level register k/8
	function automatic irq_lvl_t level_of(input int k);
		return lv[k / 8][4 * (k % 8) +: 4];
	endfunction

	// highest numbered source that is both pending and enabled or 0 when there is none
	function automatic cause_t top_source(input reg32_t pend, input reg32_t en);
		cause_t w;
		w = '0;
		for (int k = 31; k > 0; k--) begin
			if (w == '0 && pend[k] && en[k])
				w = cause_t'(k);
		end
		return w;
	endfunction

	task automatic stop_fail();
		$display("Simulation failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, got);
			stop_fail();
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	// ====================
	// bus master
	// ====================
	// one request with the response returned as {ack, err}
	task automatic bus_cycle(input logic wr, input addr_t adr, input data_t wdat,
			output data_t rdat, output logic [1:0] rsp);
		int n;
		n     = 0;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = wr;
		adr_i = {adr[31:3], 3'b000};  // 64 bit master drives whole words
		sel_i = adr[2] ? 8'hF0 : 8'h0F;  // a2 picks the lane
		dat_i = wdat;
		do begin
			@(posedge clk_i);
			#1;
			n++;
		end while (!ack_o && !err_o && n < 16);
		assert (ack_o || err_o) else begin
			$display("no bus response from %h after %0d cycles in %s", adr, n, test_name);
			stop_fail();
		end
		rdat  = dat_o;
		rsp   = {ack_o, err_o};
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		@(posedge clk_i);  // idle cycle before the next request
		#1;
	endtask

	task automatic reg_write(input addr_t adr, input reg32_t val);
		data_t      rd;
		logic [1:0] rsp;
		reg32_t     junk;
		junk = rand32();  // unused lane carries noise
		bus_cycle(1'b1, adr, adr[2] ? {val, junk} : {junk, val}, rd, rsp);
		check_eq("write ack", 64'(2'b10), 64'(rsp));
	endtask

	task automatic reg_expect(input addr_t adr, input reg32_t val);
		data_t      rd;
		logic [1:0] rsp;
		bus_cycle(1'b0, adr, '0, rd, rsp);
		check_eq("read ack", 64'(2'b10), 64'(rsp));
		check_eq($sformatf("read %h", adr), {val, val}, rd);  // both halves mirror
	endtask

	task automatic unmapped_access(input logic wr, input addr_t adr);
		data_t      rd;
		logic [1:0] rsp;
		bus_cycle(wr, adr, {rand32(), rand32()}, rd, rsp);
		check_eq($sformatf("err from %h", adr), 64'(2'b01), 64'(rsp));
	endtask

	// cycles to the next timer 2 pulse with the gate held low for the first gl
	task automatic pulse_interval(input int gl, output int n);
		n = 0;
		if (gl > 0)
			pit_gate2_i = 1'b0;
		do begin
			@(posedge clk_i);
			#1;
			n++;
			if (n == gl)
				pit_gate2_i = 1'b1;
		end while (!pit_out2_o && n < 200);
		assert (pit_out2_o) else begin
			$display("timer 2 gave no pulse within %0d cycles in %s", n, test_name);
			stop_fail();
		end
	endtask

	task automatic wait_cause(input cause_t want, input int limit);
		int n;
		n = 0;
		while (cause_o !== want && n < limit) begin
			@(posedge clk_i);
			#1;
			n++;
		end
		assert (cause_o === want) else begin
			$display("cause never reached %0d within %0d cycles in %s", want, limit, test_name);
			stop_fail();
		end
	endtask

	// ====================
	// stimulus
	// ====================
	initial begin : main
		int          r;
		int          g;
		int          n;
		int          e;
		int          b;
		reg32_t      en;
		reg32_t      rl;
		reg32_t      rv;
		cause_t      w;
		logic [28:0] s;
		clk_i       = 1'b0;
		rst_n_i     = 1'b0;
		cyc_i       = 1'b0;
		stb_i       = 1'b0;
		we_i        = 1'b0;
		adr_i       = '0;
		sel_i       = '0;
		dat_i       = '0;
		irq_src_i   = '0;
		pit_gate2_i = 1'b1;
		rng_q       = 32'd42;
		test_name   = "reset";
		repeat (2) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		check_eq("outputs", 64'(0), 64'({ack_o, err_o, irq_o, cause_o, pit_out2_o}));
		reg_expect(pic_reg(`MPU_PIC_PENDING), 32'h0);
		reg_expect(pit_reg(2, `MPU_PIT_COUNT_OFS), 32'h0);

		test_name = "readback";  // upper lane for ENABLE, RELOAD, LEVEL1 and LEVEL3
		en = rand32();
		reg_write(pic_reg(`MPU_PIC_ENABLE), en);
		reg_expect(pic_reg(`MPU_PIC_ENABLE), en);
		for (int i = 0; i < 4; i++) begin
			lv[i] = rand32();
			reg_write(pic_reg(`MPU_PIC_LEVEL0 + 6'(4 * i)), lv[i]);
		end
		for (int i = 0; i < 4; i++)
			reg_expect(pic_reg(`MPU_PIC_LEVEL0 + 6'(4 * i)), lv[i]);
		rl = rand32();
		reg_write(pit_reg(1, `MPU_PIT_RELOAD_OFS), rl);
		reg_expect(pit_reg(1, `MPU_PIT_RELOAD_OFS), rl);

		test_name = "unmapped";
		rv = rand32();
		unmapped_access(1'b1, {8'h12, rv[15:0], 8'h04});
		unmapped_access(1'b1, `MPU_PIT_BASE + 32'h114);  // reload offset in the next block up
		unmapped_access(1'b0, `MPU_PIC_BASE - 32'h100);
		reg_expect(pic_reg(`MPU_PIC_ENABLE), en);  // nothing moved
		reg_expect(pit_reg(1, `MPU_PIT_RELOAD_OFS), rl);

		test_name = "timer period";
		r = 5 + int'(rand32() % 32'd8);
		reg_write(pit_reg(2, `MPU_PIT_RELOAD_OFS), reg32_t'(r));
		reg_write(pit_reg(2, `MPU_PIT_CTRL_OFS), 32'h7);  // enable, auto reload, load now
		pulse_interval(0, n);  // line up on a pulse
		for (int i = 0; i < 2; i++) begin
			pulse_interval(0, n);
			check_eq("period", 64'(r + 1), 64'(n));
		end
		test_name = "timer gate";
		g = 1 + int'(rand32() % 32'd6);
		pulse_interval(g, n);
		check_eq("gated interval", 64'(r + 1 + g), 64'(n));
		pulse_interval(0, n);  // back to normal
		check_eq("next interval", 64'(r + 1), 64'(n));
		reg_write(pit_reg(2, `MPU_PIT_CTRL_OFS), 32'h0);

		test_name = "priority";
		for (int i = 0; i < 10; i++) begin
			en = rand32() & 32'h1FFF_FFFE;  // timer sources stay masked
			rv = rand32();
			s  = rv[28:0];
			if (i == 9)
				s = s & ~en[28:0];  // nothing qualifies
			reg_write(pic_reg(`MPU_PIC_ENABLE), en);
			irq_src_i = s;
			wait_cycles(1);  // cause and level are registered
			w = top_source({3'b000, s}, en);
			check_eq("cause", 64'(w), 64'(cause_o));
			check_eq("level", 64'(w != '0 ? level_of(int'(w)) : 4'h0), 64'(irq_o));
		end

		test_name = "edge capture";
		irq_src_i = '0;
		e = 20 + int'(rand32() % 32'd8);  // edge source
		b = 1 + int'(rand32() % 32'd10);  // level source below it
		reg_write(pic_reg(`MPU_PIC_EDGE), 32'd1 << e);
		reg_write(pic_reg(`MPU_PIC_ENABLE), (32'd1 << e) | (32'd1 << b));
		irq_src_i[b] = 1'b1;
		wait_cycles(1);
		check_eq("cause before pulse", 64'(b), 64'(cause_o));
		irq_src_i[e] = 1'b1;
		wait_cycles(1);
		irq_src_i[e] = 1'b0;  // one cycle pulse
		wait_cause(cause_t'(e), 8);
		wait_cycles(3);
		check_eq("cause held", 64'(e), 64'(cause_o));
		check_eq("level held", 64'(level_of(e)), 64'(irq_o));
		reg_expect(pic_reg(`MPU_PIC_PENDING), (32'd1 << e) | (32'd1 << b));
		reg_write(pic_reg(`MPU_PIC_PENDING), 32'd1 << e);
		check_eq("cause after clear", 64'(b), 64'(cause_o));
		check_eq("level after clear", 64'(level_of(b)), 64'(irq_o));
		reg_expect(pic_reg(`MPU_PIC_PENDING), 32'd1 << b);  // only the live level

		test_name = "timer irq";
		irq_src_i = '0;
		reg_write(pic_reg(`MPU_PIC_EDGE), 32'h8000_0000);
		reg_write(pic_reg(`MPU_PIC_ENABLE), 32'h8000_0000);
		reg_write(pic_reg(`MPU_PIC_PENDING), 32'hFFFF_FFFF);
		check_eq("cause idle", 64'(0), 64'(cause_o));
		r = 10 + int'(rand32() % 32'd16);
		reg_write(pit_reg(0, `MPU_PIT_RELOAD_OFS), reg32_t'(r));
		reg_write(pit_reg(0, `MPU_PIT_CTRL_OFS), 32'h5);  // one shot with load now
		wait_cause(cause_t'(31), 200);
		check_eq("timer level", 64'(level_of(31)), 64'(irq_o));
		reg_expect(pit_reg(0, `MPU_PIT_CTRL_OFS), 32'h0);  // enable dropped at zero
		reg_expect(pit_reg(0, `MPU_PIT_COUNT_OFS), 32'h0);

		$display("Simulation passed");
		$finish;
	end

endmodule
